/* common/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

    // width of the data bus and of every slave read word
    parameter int DATA_W = 32;

    // the top nibble of the address picks the region
    parameter int REGION_MSB = 31;
    parameter int REGION_LSB = 28;

    // peripherals decode word registers from address bits 3 to 2
    parameter int REG_SEL_MSB = 3;
    parameter int REG_SEL_LSB = 2;

    // region codes in a kseg-like layout, every other code is unmapped
    parameter logic [REGION_MSB-REGION_LSB:0] REGION_RAM    = 4'h8;
    parameter logic [REGION_MSB-REGION_LSB:0] REGION_GPIO   = 4'hB;
    parameter logic [REGION_MSB-REGION_LSB:0] REGION_TICKER = 4'hC;

    // internal select shared by the decoder and the result stage
    parameter int SEL_W = 2;

    parameter logic [SEL_W-1:0] SEL_NONE   = 2'd0;
    parameter logic [SEL_W-1:0] SEL_RAM    = 2'd1;
    parameter logic [SEL_W-1:0] SEL_GPIO   = 2'd2;
    parameter logic [SEL_W-1:0] SEL_TICKER = 2'd3;

    // GPIO register offsets
    parameter logic [REG_SEL_MSB-REG_SEL_LSB:0] GPIO_REG_OUT = 2'd0;
    parameter logic [REG_SEL_MSB-REG_SEL_LSB:0] GPIO_REG_IN  = 2'd1;

    // ticker register offsets
    parameter logic [REG_SEL_MSB-REG_SEL_LSB:0] TICK_REG_COUNT = 2'd0;
    parameter logic [REG_SEL_MSB-REG_SEL_LSB:0] TICK_REG_CMP   = 2'd1;

endpackage

`default_nettype wire

/* design/dbus_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_decode #(
    parameter int RAM_AW = 10
) (
    input  wire logic [dbus_pkg::DATA_W-1:0]                      master_address_i,
    input  wire logic                                             master_read_i,
    input  wire logic                                             master_write_i,
    output logic                                                  ram_rd_o,
    output logic                                                  ram_wr_o,
    output logic [RAM_AW-1:0]                                     ram_addr_o,
    output logic                                                  gpio_rd_o,
    output logic                                                  gpio_wr_o,
    output logic                                                  tick_rd_o,
    output logic                                                  tick_wr_o,
    output logic [dbus_pkg::REG_SEL_MSB-dbus_pkg::REG_SEL_LSB:0]  reg_sel_o,
    output logic [dbus_pkg::SEL_W-1:0]                            sel_o,
    output logic                                                  rd_req_o
);

    logic [dbus_pkg::REGION_MSB-dbus_pkg::REGION_LSB:0] region;

    assign region = master_address_i[dbus_pkg::REGION_MSB:dbus_pkg::REGION_LSB];

    always_comb begin
        case (region)
            dbus_pkg::REGION_RAM:    sel_o = dbus_pkg::SEL_RAM;
            dbus_pkg::REGION_GPIO:   sel_o = dbus_pkg::SEL_GPIO;
            dbus_pkg::REGION_TICKER: sel_o = dbus_pkg::SEL_TICKER;
            default:                 sel_o = dbus_pkg::SEL_NONE;
        endcase
    end

    // unmapped reads still go to the result stage so they get their stall cycle
    assign rd_req_o = master_read_i;

    assign ram_rd_o  = master_read_i  && (sel_o == dbus_pkg::SEL_RAM);
    assign ram_wr_o  = master_write_i && (sel_o == dbus_pkg::SEL_RAM);
    assign gpio_rd_o = master_read_i  && (sel_o == dbus_pkg::SEL_GPIO);
    assign gpio_wr_o = master_write_i && (sel_o == dbus_pkg::SEL_GPIO);
    assign tick_rd_o = master_read_i  && (sel_o == dbus_pkg::SEL_TICKER);
    assign tick_wr_o = master_write_i && (sel_o == dbus_pkg::SEL_TICKER);

    assign ram_addr_o = master_address_i[dbus_pkg::REG_SEL_LSB +: RAM_AW]; // word index
    assign reg_sel_o  = master_address_i[dbus_pkg::REG_SEL_MSB:dbus_pkg::REG_SEL_LSB];

endmodule

`default_nettype wire

/* design/dbus_result.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_result (
    input  wire logic                          clk_bus_i,
    input  wire logic                          reset_i,
    input  wire logic [dbus_pkg::SEL_W-1:0]    sel_i,
    input  wire logic                          rd_req_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]   ram_rdata_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]   gpio_rdata_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]   tick_rdata_i,
    output logic      [dbus_pkg::DATA_W-1:0]   master_rddata_o,
    output logic                               master_stall_o
);

    logic [dbus_pkg::SEL_W-1:0] sel_q;
    logic                       pending_q;
    logic                       first_cycle;

    assign first_cycle = rd_req_i && !pending_q; // a new read, slaves capture this cycle

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
            sel_q     <= dbus_pkg::SEL_NONE;
        end else begin
            pending_q <= first_cycle; // drops after one cycle so a held read starts over
            if (first_cycle) begin
                sel_q <= sel_i;
            end
        end
    end

    assign master_stall_o = first_cycle;

    always_comb begin
        case (sel_q)
            dbus_pkg::SEL_RAM:    master_rddata_o = ram_rdata_i;
            dbus_pkg::SEL_GPIO:   master_rddata_o = gpio_rdata_i;
            dbus_pkg::SEL_TICKER: master_rddata_o = tick_rdata_i;
            default:              master_rddata_o = '0; // unmapped reads return zero
        endcase
    end

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int RAM_AW = 10
) (
    input  wire logic                            clk_bus_i,
    input  wire logic                            rd_i,
    input  wire logic                            wr_i,
    input  wire logic [RAM_AW-1:0]               addr_i,
    input  wire logic [dbus_pkg::DATA_W/8-1:0]   be_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]     wdata_i,
    output logic      [dbus_pkg::DATA_W-1:0]     rdata_o
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [dbus_pkg::DATA_W-1:0] mem [DEPTH];

    // each enabled byte lane is written on its own
    always_ff @(posedge clk_bus_i) begin
        if (wr_i) begin
            for (int b = 0; b < dbus_pkg::DATA_W / 8; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (rd_i) begin
            rdata_o <= mem[addr_i]; // valid the cycle after the strobe
        end
    end

endmodule

`default_nettype wire

/* design/gpio_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_regs #(
    parameter int GPIO_W = 16
) (
    input  wire logic                                            clk_bus_i,
    input  wire logic                                            reset_i,
    input  wire logic                                            rd_i,
    input  wire logic                                            wr_i,
    input  wire logic [dbus_pkg::REG_SEL_MSB-dbus_pkg::REG_SEL_LSB:0] reg_sel_i,
    input  wire logic [dbus_pkg::DATA_W/8-1:0]                   be_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]                     wdata_i,
    input  wire logic [GPIO_W-1:0]                               gpio_i,
    output logic      [dbus_pkg::DATA_W-1:0]                     rdata_o,
    output logic      [GPIO_W-1:0]                               gpio_o
);

    logic [GPIO_W-1:0]           out_q;
    logic [GPIO_W-1:0]           in_meta_q;
    logic [GPIO_W-1:0]           in_sync_q;
    logic [dbus_pkg::DATA_W-1:0] rd_word;

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (wr_i && reg_sel_i == dbus_pkg::GPIO_REG_OUT) begin
            for (int i = 0; i < GPIO_W; i++) begin
                if (be_i[i/8]) begin
                    out_q[i] <= wdata_i[i];
                end
            end
        end
    end

    // pins are asynchronous to the bus so they go through two flops
    always_ff @(posedge clk_bus_i) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        rd_word = '0;
        case (reg_sel_i)
            dbus_pkg::GPIO_REG_OUT: rd_word[GPIO_W-1:0] = out_q;
            dbus_pkg::GPIO_REG_IN:  rd_word[GPIO_W-1:0] = in_sync_q;
            default:                rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_bus_i) begin
        if (rd_i) begin
            rdata_o <= rd_word;
        end
    end

    assign gpio_o = out_q;

endmodule

`default_nettype wire

/* design/ticker.sv */
`timescale 1ns/100ps
`default_nettype none

module ticker #(
    parameter int TICK_DIV = 4
) (
    input  wire logic                                            clk_bus_i,
    input  wire logic                                            reset_i,
    input  wire logic                                            rd_i,
    input  wire logic                                            wr_i,
    input  wire logic [dbus_pkg::REG_SEL_MSB-dbus_pkg::REG_SEL_LSB:0] reg_sel_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]                     wdata_i,
    output logic      [dbus_pkg::DATA_W-1:0]                     rdata_o,
    output logic                                                 timer_irq_o
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]            pre_q;
    logic [dbus_pkg::DATA_W-1:0] count_q;
    logic [dbus_pkg::DATA_W-1:0] cmp_q;
    logic                        irq_q;
    logic                        tick;
    logic                        wr_count;
    logic                        wr_cmp;

    assign tick     = (pre_q == PRE_W'(TICK_DIV - 1));
    assign wr_count = wr_i && (reg_sel_i == dbus_pkg::TICK_REG_COUNT);
    assign wr_cmp   = wr_i && (reg_sel_i == dbus_pkg::TICK_REG_CMP);

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            pre_q   <= '0;
            count_q <= '0;
        end else if (wr_count) begin
            pre_q   <= '0; // loading the count restarts the prescaler
            count_q <= wdata_i;
        end else if (tick) begin
            pre_q   <= '0;
            count_q <= count_q + 1'b1;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            cmp_q <= '1;
            irq_q <= 1'b0;
        end else if (wr_cmp) begin
            cmp_q <= wdata_i;
            irq_q <= 1'b0; // rewriting the compare value is the acknowledge
        end else if (count_q == cmp_q) begin
            irq_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (rd_i) begin
            case (reg_sel_i)
                dbus_pkg::TICK_REG_COUNT: rdata_o <= count_q;
                dbus_pkg::TICK_REG_CMP:   rdata_o <= cmp_q;
                default:                  rdata_o <= '0;
            endcase
        end
    end

    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* design/dbus_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_subsys #(
    parameter int RAM_AW   = 10,
    parameter int GPIO_W   = 16,
    parameter int TICK_DIV = 4
) (
    input  wire logic                            clk_bus_i,
    input  wire logic                            reset_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]     master_address_i,
    input  wire logic [dbus_pkg::DATA_W/8-1:0]   master_byteenable_i,
    input  wire logic                            master_read_i,
    input  wire logic                            master_write_i,
    input  wire logic [dbus_pkg::DATA_W-1:0]     master_wrdata_i,
    input  wire logic [GPIO_W-1:0]               gpio_i,
    output logic      [dbus_pkg::DATA_W-1:0]     master_rddata_o,
    output logic                                 master_stall_o,
    output logic      [GPIO_W-1:0]               gpio_o,
    output logic                                 timer_irq_o
);

    logic                                                 ram_rd;
    logic                                                 ram_wr;
    logic [RAM_AW-1:0]                                    ram_addr;
    logic                                                 gpio_rd;
    logic                                                 gpio_wr;
    logic                                                 tick_rd;
    logic                                                 tick_wr;
    logic [dbus_pkg::REG_SEL_MSB-dbus_pkg::REG_SEL_LSB:0] reg_sel;
    logic [dbus_pkg::SEL_W-1:0]                           sel;
    logic                                                 rd_req;
    logic [dbus_pkg::DATA_W-1:0]                          ram_rdata;
    logic [dbus_pkg::DATA_W-1:0]                          gpio_rdata;
    logic [dbus_pkg::DATA_W-1:0]                          tick_rdata;

    dbus_decode #(.RAM_AW(RAM_AW)) dbus_decode_inst (
        .master_address_i (master_address_i),
        .master_read_i    (master_read_i),
        .master_write_i   (master_write_i),
        .ram_rd_o         (ram_rd),
        .ram_wr_o         (ram_wr),
        .ram_addr_o       (ram_addr),
        .gpio_rd_o        (gpio_rd),
        .gpio_wr_o        (gpio_wr),
        .tick_rd_o        (tick_rd),
        .tick_wr_o        (tick_wr),
        .reg_sel_o        (reg_sel),
        .sel_o            (sel),
        .rd_req_o         (rd_req)
    );

    data_ram #(.RAM_AW(RAM_AW)) data_ram_inst (
        .clk_bus_i (clk_bus_i),
        .rd_i      (ram_rd),
        .wr_i      (ram_wr),
        .addr_i    (ram_addr),
        .be_i      (master_byteenable_i),
        .wdata_i   (master_wrdata_i),
        .rdata_o   (ram_rdata)
    );

    gpio_regs #(.GPIO_W(GPIO_W)) gpio_regs_inst (
        .clk_bus_i (clk_bus_i),
        .reset_i   (reset_i),
        .rd_i      (gpio_rd),
        .wr_i      (gpio_wr),
        .reg_sel_i (reg_sel),
        .be_i      (master_byteenable_i),
        .wdata_i   (master_wrdata_i),
        .gpio_i    (gpio_i),
        .rdata_o   (gpio_rdata),
        .gpio_o    (gpio_o)
    );

    ticker #(.TICK_DIV(TICK_DIV)) ticker_inst (
        .clk_bus_i   (clk_bus_i),
        .reset_i     (reset_i),
        .rd_i        (tick_rd),
        .wr_i        (tick_wr),
        .reg_sel_i   (reg_sel),
        .wdata_i     (master_wrdata_i), // ticker registers are always written as whole words
        .rdata_o     (tick_rdata),
        .timer_irq_o (timer_irq_o)
    );

    dbus_result dbus_result_inst (
        .clk_bus_i       (clk_bus_i),
        .reset_i         (reset_i),
        .sel_i           (sel),
        .rd_req_i        (rd_req),
        .ram_rdata_i     (ram_rdata),
        .gpio_rdata_i    (gpio_rdata),
        .tick_rdata_i    (tick_rdata),
        .master_rddata_o (master_rddata_o),
        .master_stall_o  (master_stall_o)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS   = 8,
    parameter int RESET_EDGES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_EDGES) @(posedge clk_o);
        #1;
        reset_o = 1'b0; // released just after an edge like the other inputs
    end

endmodule

`default_nettype wire

/* test/tb_dbus.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dbus;

    localparam int RAM_AW    = 10;
    localparam int GPIO_W    = 16;
    localparam int TICK_DIV  = 4;
    localparam int RAM_WORDS = 64; // the random RAM traffic uses this many words spread over the RAM
    localparam int RAM_OPS   = 200;

    localparam int TEST_CYCLES = 10 + (RAM_WORDS + 2 * RAM_OPS) + 20 + (1 + 4 * 22)
                               + (5 * TICK_DIV + 2 + 16) + 12;
    localparam int WATCHDOG_NS = 8 * TEST_CYCLES + 2000;

    localparam logic [31:0] GPIO_OUT_ADDR   = 32'hB000_0000;
    localparam logic [31:0] GPIO_IN_ADDR    = 32'hB000_0004;
    localparam logic [31:0] TICK_COUNT_ADDR = 32'hC000_0000;
    localparam logic [31:0] TICK_CMP_ADDR   = 32'hC000_0004;

    logic                          clk_bus;
    logic                          reset_bus;
    logic [dbus_pkg::DATA_W-1:0]   address;
    logic [dbus_pkg::DATA_W/8-1:0] byteenable;
    logic                          read;
    logic                          write;
    logic [dbus_pkg::DATA_W-1:0]   wrdata;
    logic [GPIO_W-1:0]             gpio_in;
    logic [dbus_pkg::DATA_W-1:0]   rddata;
    logic                          stall;
    logic [GPIO_W-1:0]             gpio_out;
    logic                          timer_irq;

    int                pass_count;
    int                fail_count;
    int                cycle_count;
    logic [31:0]       ram_model [RAM_WORDS];
    logic [GPIO_W-1:0] gpio_model;

    tb_clock #(.PERIOD_NS(8), .RESET_EDGES(2)) tb_clock_inst (
        .clk_o   (clk_bus),
        .reset_o (reset_bus)
    );

    dbus_subsys #(
        .RAM_AW   (RAM_AW),
        .GPIO_W   (GPIO_W),
        .TICK_DIV (TICK_DIV)
    ) dbus_subsys_inst (
        .clk_bus_i           (clk_bus),
        .reset_i             (reset_bus),
        .master_address_i    (address),
        .master_byteenable_i (byteenable),
        .master_read_i       (read),
        .master_write_i      (write),
        .master_wrdata_i     (wrdata),
        .gpio_i              (gpio_in),
        .master_rddata_o     (rddata),
        .master_stall_o      (stall),
        .gpio_o              (gpio_out),
        .timer_irq_o         (timer_irq)
    );

    always @(posedge clk_bus) begin
        cycle_count <= cycle_count + 1;
    end

    assert property (@(posedge clk_bus) disable iff (reset_bus) write |-> !stall)
        else begin
            fail_count++;
            $display("Failure: a write was stalled at %0t", $time);
        end

    // the stall of a read never lasts into a second cycle
    assert property (@(posedge clk_bus) disable iff (reset_bus) (read && stall) |=> !stall)
        else begin
            fail_count++;
            $display("Failure: a read stayed stalled for a second cycle at %0t", $time);
        end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("** Error %s expected %08h actual %08h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_range(input string name, input logic [31:0] low,
                               input logic [31:0] high, input logic [31:0] actual);
        assert (actual >= low && actual <= high) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("** Error %s expected %08h to %08h actual %08h at %0t", name, low, high,
                     actual, $time);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Failure: %s at %0t", what, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_bus);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        address    = addr;
        byteenable = be;
        wrdata     = data;
        write      = 1'b1;
        next_cycle();
        write = 1'b0;
    endtask

    // samples at the falling edge, where stall and read data are settled
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int stall_cycles;
        stall_cycles = 0;
        address      = addr;
        read         = 1'b1;
        @(negedge clk_bus);
        while (stall && stall_cycles < 8) begin
            stall_cycles++;
            @(negedge clk_bus);
        end
        check_true(!stall, "a read was never released from its stall");
        check_true(stall_cycles == 1,
                   $sformatf("a read was stalled for %0d cycles instead of one", stall_cycles));
        data = rddata;
        next_cycle();
        read = 1'b0;
    endtask

    // the modelled words are spread out so that every bit of the RAM word index toggles
    function automatic logic [31:0] ram_addr(input int idx);
        return 32'h8000_0000 | (32'((idx << 4) | (idx & 15)) << 2);
    endfunction

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failing checks", name, fail_count - fails_before);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] prev;
        logic [31:0] value;
        logic [31:0] ticks;
        logic [3:0]  be;
        int          fails_before;
        int          idx;
        int          start_cycle;
        int          waited;
        address     = '0;
        byteenable  = '0;
        read        = 1'b0;
        write       = 1'b0;
        wrdata      = '0;
        gpio_in     = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        void'($urandom(2));
        @(posedge clk_bus);
        while (reset_bus) @(posedge clk_bus);
        #1;

        fails_before = fail_count;
        check_word("master_stall_o", 32'h0, {31'h0, stall});
        check_word("timer_irq_o", 32'h0, {31'h0, timer_irq});
        check_word("gpio_o", 32'h0, 32'(gpio_out));
        bus_write(ram_addr(3), 4'hF, 32'h1234_5678);
        bus_read(ram_addr(3), data);
        check_word("master_rddata_o", 32'h1234_5678, data);
        bus_read(ram_addr(3), data); // held read counts as a new one
        check_word("master_rddata_o", 32'h1234_5678, data);
        report_test("read stall timing", fails_before);

        fails_before = fail_count;
        for (idx = 0; idx < RAM_WORDS; idx++) begin
            ram_model[idx] = 32'hA500_0000 ^ (32'(idx) * 32'h0001_0101);
            bus_write(ram_addr(idx), 4'hF, ram_model[idx]);
        end
        for (int op = 0; op < RAM_OPS; op++) begin
            idx = int'($urandom_range(RAM_WORDS - 1));
            if ($urandom_range(1) == 1) begin
                be    = 4'($urandom);
                value = $urandom;
                bus_write(ram_addr(idx), be, value);
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        ram_model[idx][b*8 +: 8] = value[b*8 +: 8];
                    end
                end
            end else begin
                bus_read(ram_addr(idx), data);
                check_word("master_rddata_o", ram_model[idx], data);
            end
        end
        report_test("ram byte enables", fails_before);

        fails_before = fail_count;
        gpio_model = 16'hC3A5;
        bus_write(GPIO_OUT_ADDR, 4'hF, {16'hFFFF, gpio_model});
        check_word("gpio_o", 32'(gpio_model), 32'(gpio_out));
        gpio_model[15:8] = 8'h5A;
        bus_write(GPIO_OUT_ADDR, 4'b0010, 32'h1111_5A11);
        check_word("gpio_o", 32'(gpio_model), 32'(gpio_out));
        bus_read(GPIO_OUT_ADDR, data);
        check_word("master_rddata_o", 32'(gpio_model), data);
        gpio_in = 16'h9E21;
        repeat (3) next_cycle();
        bus_read(GPIO_IN_ADDR, data);
        check_word("master_rddata_o", 32'h0000_9E21, data);
        bus_write(GPIO_IN_ADDR, 4'hF, 32'h0000_FFFF);
        check_word("gpio_o", 32'(gpio_model), 32'(gpio_out));
        bus_read(GPIO_IN_ADDR, data);
        check_word("master_rddata_o", 32'h0000_9E21, data);
        bus_read(GPIO_OUT_ADDR, data);
        check_word("master_rddata_o", 32'(gpio_model), data);
        report_test("gpio", fails_before);

        fails_before = fail_count;
        value       = 32'h0100_0000 | 32'($urandom_range(32'h00FF_FFFF));
        start_cycle = cycle_count;
        bus_write(TICK_COUNT_ADDR, 4'hF, value);
        prev = value;
        for (int n = 0; n < 4; n++) begin
            repeat (int'($urandom_range(20, 1))) next_cycle();
            bus_read(TICK_COUNT_ADDR, data);
            ticks = 32'((cycle_count - start_cycle) / TICK_DIV);
            check_range("master_rddata_o", value + ticks - 32'd1, value + ticks + 32'd1, data);
            check_true(data >= prev, "the ticker count went backwards");
            prev = data;
        end
        report_test("ticker counting", fails_before);

        fails_before = fail_count;
        bus_write(TICK_COUNT_ADDR, 4'hF, 32'h0);
        bus_write(TICK_CMP_ADDR, 4'hF, 32'h5);
        check_word("timer_irq_o", 32'h0, {31'h0, timer_irq});
        waited = 0;
        while (!timer_irq && waited < 5 * TICK_DIV + 2) begin
            next_cycle();
            waited++;
        end
        check_true(timer_irq, "timer_irq_o did not rise in time after the compare was set");
        repeat (8) begin
            next_cycle();
            check_word("timer_irq_o", 32'h1, {31'h0, timer_irq});
        end
        bus_read(TICK_CMP_ADDR, data);
        check_word("master_rddata_o", 32'h5, data);
        check_word("timer_irq_o", 32'h1, {31'h0, timer_irq});
        bus_write(TICK_CMP_ADDR, 4'hF, 32'hFFFF_FFFF);
        check_word("timer_irq_o", 32'h0, {31'h0, timer_irq});
        next_cycle();
        check_word("timer_irq_o", 32'h0, {31'h0, timer_irq});
        report_test("timer interrupt", fails_before);

        fails_before = fail_count;
        bus_read(32'h0000_0010, data);
        check_word("master_rddata_o", 32'h0, data);
        bus_read(32'h4000_0000, data);
        check_word("master_rddata_o", 32'h0, data);
        bus_write(ram_addr(5) & 32'h0FFF_FFFF, 4'hF, 32'hDEAD_BEEF); // offset of RAM word 5
        bus_write(32'h0000_0000, 4'hF, 32'h0000_FFFF); // same offset as the GPIO OUT register
        bus_read(ram_addr(5), data);
        check_word("master_rddata_o", ram_model[5], data);
        bus_read(GPIO_OUT_ADDR, data);
        check_word("master_rddata_o", 32'(gpio_model), data);
        check_word("gpio_o", 32'(gpio_model), 32'(gpio_out));
        report_test("unmapped region", fails_before);

        $display("closing count: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/dbus_pkg.sv
design/dbus_decode.sv
design/dbus_result.sv
design/data_ram.sv
design/gpio_regs.sv
design/ticker.sv
design/dbus_subsys.sv
test/tb_clock.sv
test/tb_dbus.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dbus \
        -f all.f -o tb_dbus_sim > build.log 2>&1 \
    && ./obj_dir/tb_dbus_sim > sim.log 2>&1 \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
